// File: list.f
+incdir+include
verilog/spio_rx_pkg.sv
verilog/link_sampler.sv
verilog/flit_counter.sv
verilog/pkt_fsm.sv
verilog/pkt_assembler.sv
verilog/spio_link_receiver.sv
tests/spio_rx_assert.sv
tests/tb_spio_link_receiver.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
SIMFLAGS  = +verilator+error+limit+1000
TOP       = tb_spio_link_receiver
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tests/tb_spio_link_receiver.sv
`include "spio_rx_config.svh"

module tb_spio_link_receiver import spio_rx_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int      CLK_PERIOD = 8;
  localparam int      NUM_TESTS  = 10;
  localparam int      ACK_LIMIT  = 1000;        // cycles the sender waits for one ack
  localparam int      SETTLE     = 8;           // quiet cycles for stray packets
  localparam symbol_t ERR_SYMBOL = 7'b0000111;  // three wires, never a code
  // 2-of-7 data codes, indexed by nibble
  localparam symbol_t DATA_CODE [16] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001
  };

  typedef enum logic [1:0] {row_short, row_long, row_error, row_early} row_kind_t;

  // nibble i of a row sits at bits 4i+3:4i
  typedef struct packed {
    row_kind_t kind;
    int        n_nib;      // data symbols before the error or eop
    pkt_data_t nibs;
    int        ready_pct;  // chance of pkt_ready per cycle
    logic      has_pkt;    // low means no packet expected
    pkt_data_t exp_pkt;
  } test_row_t;

  logic      CLK_IN;
  logic      RESET_IN;
  symbol_t   link_data;
  logic      link_ack;
  pkt_data_t pkt_data;
  logic      pkt_valid;
  logic      pkt_ready;

  test_row_t rows [NUM_TESTS];
  pkt_data_t rx_q [$];     // packets taken by the sink, in order
  pkt_data_t exp_q [$];    // packets expected so far, in order
  symbol_t   nrz;          // wire levels the sender holds
  logic      ack_level;    // ack level the sender waits for
  int        seed = 43842;
  int        cur_pct;
  int        n_checked;    // received packets already compared
  int        errors;
  int        wd_cycles;
  bit        aborted;      // sender gave up

  spio_link_receiver dut_i (.*);

  initial begin
    CLK_IN = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_IN = ~CLK_IN;
  end

  // packet sink records a packet once the handshake is set up for the next edge
  initial begin
    forever begin
      @(posedge CLK_IN);
      #1;
      pkt_ready = ({$random(seed)} % 100) < cur_pct;
      if (pkt_valid && pkt_ready) rx_q.push_back(pkt_data);
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_pkt(input string what, input pkt_data_t got, input pkt_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_len(input string what, input flit_cnt_t got, input flit_cnt_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // link sender
  // ----------------------------------------
  task automatic wait_ack();
    int waited;
    waited = 0;
    while (link_ack !== ack_level && waited < ACK_LIMIT) begin
      @(posedge CLK_IN);
      #1;
      waited++;
    end
    if (link_ack !== ack_level) begin
      errors++;
      aborted = 1'b1;
      $display("link_ack did not toggle within %0d cycles, sender stops", ACK_LIMIT);
    end
  endtask

  task automatic send_symbol(input symbol_t code);
    if (aborted) return;
    @(posedge CLK_IN);
    #1;
    if (link_ack !== ack_level) begin
      errors++;
      $display("link_ack toggled before %0t with no symbol pending", $time);
    end
    nrz       = nrz ^ code;  // only the code wires flip
    link_data = nrz;
    ack_level = ~ack_level;
    wait_ack();
  endtask

  // rows 6 and 7 keep the port full so that row 8 stalls the link
  task automatic fill_table();
    rows[0] = '{row_short, 10, 72'h000000005a3ce19f40, 100, 1'b1, 72'h000000005a3ce19f40};
    rows[1] = '{row_long,  18, 72'h0123456789abcdef02, 100, 1'b1, 72'h0123456789abcdef02};
    rows[2] = '{row_error,  5, 72'h0000000000000b7c31, 100, 1'b0, 72'h0};
    rows[3] = '{row_short, 10, 72'h00000000fedcba9810, 100, 1'b1, 72'h00000000fedcba9810};
    rows[4] = '{row_early,  7, 72'h00000000000a5c3d16, 100, 1'b0, 72'h0};
    rows[5] = '{row_long,  18, 72'h3c5a96f0e1d2b4870e, 100, 1'b1, 72'h3c5a96f0e1d2b4870e};
    rows[6] = '{row_short, 10, 72'h0000000077c0ffee08,   0, 1'b1, 72'h0000000077c0ffee08};
    rows[7] = '{row_long,  18, 72'hdeadbeef0123456783,   0, 1'b1, 72'hdeadbeef0123456783};
    rows[8] = '{row_error,  3, 72'h0000000000000009a4,   2, 1'b0, 72'h0};
    rows[9] = '{row_long,  18, 72'h8899aabbccddeeff66,  10, 1'b1, 72'h8899aabbccddeeff66};
  endtask

  function automatic int count_symbols();
    int n = 0;
    foreach (rows[i]) n += rows[i].n_nib + ((rows[i].kind == row_error) ? 2 : 1);
    return n;
  endfunction

  task automatic run_row(input int t);
    test_row_t row;
    int        errs_before;
    int        waited;
    row         = rows[t];
    errs_before = errors;
    waited      = 0;
    cur_pct     = row.ready_pct;
    for (int i = 0; i < row.n_nib; i++) begin
      send_symbol(DATA_CODE[row.nibs[4*i +: 4]]);
    end
    if (row.kind == row_error) send_symbol(ERR_SYMBOL);
    send_symbol(`SPIO_EOP_SYMBOL);
    if (row.has_pkt) exp_q.push_back(row.exp_pkt);
    // with no ready chance the packet stays in the port for a later row
    if (row.ready_pct > 0) begin
      // wait for every pending packet, then a quiet window for strays
      while (rx_q.size() < exp_q.size() && waited < ACK_LIMIT) begin
        @(negedge CLK_IN);
        waited++;
      end
      repeat (SETTLE) @(negedge CLK_IN);
      check_len("packets received", flit_cnt_t'(rx_q.size()), flit_cnt_t'(exp_q.size()));
      while (n_checked < rx_q.size() && n_checked < exp_q.size()) begin
        check_pkt("pkt_data", rx_q[n_checked], exp_q[n_checked]);
        n_checked++;
      end
    end
    $display("test %0d %s: %s", t, row.kind.name(), (errors == errs_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    RESET_IN  = 1'b1;
    link_data = '0;
    pkt_ready = 1'b0;
    nrz       = '0;
    ack_level = 1'b1;  // go-ahead level after reset
    cur_pct   = 0;
    n_checked = 0;
    errors    = 0;
    aborted   = 1'b0;
    fill_table();
    wd_cycles = 64 * count_symbols() + 1000;
    fork
      begin
        repeat (wd_cycles) @(posedge CLK_IN);
        $display("watchdog expired after %0d cycles", wd_cycles);
        $display("TESTBENCH FAILED");
        $finish;
      end
    join_none
    repeat (16) @(posedge CLK_IN);
    #1;
    RESET_IN = 1'b0;
    wait_ack();
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (!aborted) run_row(t);
    end
    errors += dut_i.assert_i.fail_count;
    $display("%0d tests, %0d packets, %0d assertion failures, %0d errors",
             NUM_TESTS, rx_q.size(), dut_i.assert_i.fail_count, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tests/spio_rx_assert.sv
module spio_rx_assert import spio_rx_pkg::*; (
  input logic      CLK_IN,
  input logic      RESET_IN,
  input pkt_data_t pkt_data,
  input logic      pkt_valid,
  input logic      pkt_ready,
  input logic      link_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // failed assertions so far

  // stalled packet must not move
  hold_pkt: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_valid && !pkt_ready) |=> (pkt_valid && $stable(pkt_data)))
    else begin
      fail_count++;
      $error("pkt_data or pkt_valid changed while pkt_ready was low");
    end

  // output register comes out of reset empty
  valid_after_reset: assert property (@(posedge CLK_IN) $fell(RESET_IN) |-> !pkt_valid)
    else begin
      fail_count++;
      $error("pkt_valid high in the cycle after reset");
    end

  // one toggle per symbol, sync delay keeps them apart
  single_ack: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    $changed(link_ack) |=> $stable(link_ack))
    else begin
      fail_count++;
      $error("link_ack toggled on two clocks in a row");
    end

endmodule

bind spio_link_receiver spio_rx_assert assert_i (
  .CLK_IN    (CLK_IN),
  .RESET_IN  (RESET_IN),
  .pkt_data  (pkt_data),
  .pkt_valid (pkt_valid),
  .pkt_ready (pkt_ready),
  .link_ack  (link_ack)
);

// File: verilog/spio_link_receiver.sv
module spio_link_receiver import spio_rx_pkg::*; (
  input  logic      CLK_IN,
  input  logic      RESET_IN,
  // spinnaker link side
  input  symbol_t   link_data,
  output logic      link_ack,
  // packet side
  output pkt_data_t pkt_data,
  output logic      pkt_valid,
  input  logic      pkt_ready
);

  // ----------------------------------------
  // internal signals
  // ----------------------------------------
  flit_t flit;         // sampler to fsm
  logic  flit_valid;
  logic  flit_ready;
  logic  count_clear;  // fsm to counter
  logic  count_step;
  logic  first_flit;
  logic  eop_due;      // counter to fsm
  logic  pkt_long;     // counter to assembler
  logic  shift_en;     // fsm to assembler
  logic  send_pkt;
  logic  pkt_busy;     // assembler to fsm

  link_sampler sampler_i (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .link_data  (link_data),
    .link_ack   (link_ack),
    .flit       (flit),
    .flit_valid (flit_valid),
    .flit_ready (flit_ready)
  );

  pkt_fsm fsm_i (
    .CLK_IN      (CLK_IN),
    .RESET_IN    (RESET_IN),
    .flit        (flit),
    .flit_valid  (flit_valid),
    .flit_ready  (flit_ready),
    .eop_due     (eop_due),
    .count_clear (count_clear),
    .count_step  (count_step),
    .first_flit  (first_flit),
    .pkt_busy    (pkt_busy),
    .shift_en    (shift_en),
    .send_pkt    (send_pkt)
  );

  flit_counter counter_i (
    .CLK_IN      (CLK_IN),
    .RESET_IN    (RESET_IN),
    .count_clear (count_clear),
    .count_step  (count_step),
    .first_flit  (first_flit),
    .nibble      (flit.nibble),
    .eop_due     (eop_due),
    .pkt_long    (pkt_long)
  );

  pkt_assembler assembler_i (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .nibble    (flit.nibble),
    .shift_en  (shift_en),
    .send_pkt  (send_pkt),
    .pkt_long  (pkt_long),
    .pkt_data  (pkt_data),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .pkt_busy  (pkt_busy)
  );

endmodule

// File: verilog/pkt_assembler.sv
`include "spio_rx_config.svh"

module pkt_assembler import spio_rx_pkg::*; (
  input  logic      CLK_IN,
  input  logic      RESET_IN,
  input  nibble_t   nibble,
  input  logic      shift_en,   // data nibble accepted
  input  logic      send_pkt,   // load the output register
  input  logic      pkt_long,
  // packet port
  output pkt_data_t pkt_data,
  output logic      pkt_valid,
  input  logic      pkt_ready,
  output logic      pkt_busy
);

  // ----------------------------------------
  // shift buffer
  // ----------------------------------------
  localparam int unsigned SHORT_SHIFT = `SPIO_PKT_BITS - `SPIO_SHORT_PKT_BITS;

  pkt_data_t buf_q;       // newest nibble on top
  pkt_data_t aligned;     // buffer as it goes out

  always_ff @(posedge CLK_IN) begin
    if (shift_en) begin
      buf_q <= {nibble, buf_q[`SPIO_PKT_BITS-1:`SPIO_NIBBLE_BITS]};
    end
  end

  // short packet sits in the top 40 bits, move it down
  assign aligned = pkt_long ? buf_q : (buf_q >> SHORT_SHIFT);

  // ----------------------------------------
  // output register
  // ----------------------------------------
  assign pkt_busy = pkt_valid && !pkt_ready;

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_valid <= 1'b0;
    end else if (send_pkt) begin
      pkt_valid <= 1'b1;
    end else if (pkt_ready) begin
      pkt_valid <= 1'b0;  // taken by the sink
    end
  end

  // fsm never sends while busy, data holds until ready
  always_ff @(posedge CLK_IN) begin
    if (send_pkt) begin
      pkt_data <= aligned;
    end
  end

endmodule

// File: verilog/pkt_fsm.sv
module pkt_fsm import spio_rx_pkg::*; (
  input  logic  CLK_IN,
  input  logic  RESET_IN,
  // flit port from the sampler
  input  flit_t flit,
  input  logic  flit_valid,
  output logic  flit_ready,
  // counter
  input  logic  eop_due,
  output logic  count_clear,
  output logic  count_step,
  output logic  first_flit,
  // assembler
  input  logic  pkt_busy,
  output logic  shift_en,
  output logic  send_pkt
);

  fsm_state_t state;
  logic       take;      // flit consumed this edge
  logic       in_data;
  logic       in_eop;
  logic       in_error;

  // ----------------------------------------
  // flit handshake and decode
  // ----------------------------------------
  // ready everywhere except start and while a packet waits for the output
  assign flit_ready = (state == st_idle) || (state == st_transfer) ||
                      (state == st_drop);

  assign take     = flit_valid && flit_ready;
  assign in_data  = take && (flit.kind == kind_data);
  assign in_eop   = take && (flit.kind == kind_eop);
  assign in_error = take && (flit.kind == kind_error);

  // ----------------------------------------
  // control outputs
  // ----------------------------------------
  assign count_clear = (state != st_transfer);  // restart outside a packet
  assign count_step  = (state == st_transfer) && in_data;
  assign first_flit  = (state == st_idle) && in_data;
  assign shift_en    = in_data && ((state == st_idle) || (state == st_transfer));

  // only when the output register is free
  assign send_pkt = !pkt_busy &&
                    (((state == st_transfer) && in_eop && eop_due) ||
                     (state == st_wait_send));

  // ----------------------------------------
  // state register
  // ----------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= st_start;
    end else begin
      case (state)
        st_start: state <= st_idle;

        st_idle: begin
          if (in_data) begin
            state <= st_transfer;     // first nibble of a packet
          end else if (in_error) begin
            state <= st_drop;
          end                         // stray eop ignored
        end

        st_transfer: begin
          if (in_error) begin
            state <= st_drop;
          end else if (in_eop) begin
            if (!eop_due) begin
              state <= st_idle;       // early eop, packet lost
            end else if (pkt_busy) begin
              state <= st_wait_send;  // complete but output full
            end else begin
              state <= st_idle;       // sent this edge
            end
          end
        end

        st_wait_send: begin
          if (!pkt_busy) begin
            state <= st_idle;         // send_pkt high this edge
          end
        end

        st_drop: begin
          if (in_eop) begin
            state <= st_idle;
          end
        end

        default: state <= st_drop;   // unreachable encodings
      endcase
    end
  end

endmodule

// File: verilog/flit_counter.sv
`include "spio_rx_config.svh"

module flit_counter import spio_rx_pkg::*; (
  input  logic    CLK_IN,
  input  logic    RESET_IN,
  input  logic    count_clear,  // back to 1, outside transfer
  input  logic    count_step,   // one more data nibble
  input  logic    first_flit,   // nibble holds the length bit
  input  nibble_t nibble,
  output logic    eop_due,      // next flit should be the eop
  output logic    pkt_long
);

  flit_cnt_t count_q;

  // the first nibble counts as 1 already
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      count_q <= flit_cnt_t'(1);
    end else if (count_clear) begin
      count_q <= flit_cnt_t'(1);
    end else if (count_step && (count_q != '1)) begin
      count_q <= count_q + flit_cnt_t'(1);  // saturates, junk never wraps to due
    end
  end

  // length comes from bit 1 of the first nibble
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_long <= 1'b0;
    end else if (first_flit) begin
      pkt_long <= nibble[1];
    end
  end

  assign eop_due = pkt_long ? (count_q == flit_cnt_t'(`SPIO_LONG_FLITS))
                            : (count_q == flit_cnt_t'(`SPIO_SHORT_FLITS));

endmodule

// File: verilog/link_sampler.sv
`include "spio_rx_config.svh"

module link_sampler import spio_rx_pkg::*; (
  input  logic    CLK_IN,
  input  logic    RESET_IN,
  // spinnaker link, 2-of-7 nrz
  input  symbol_t link_data,
  output logic    link_ack,
  // flit out to the packet fsm
  output flit_t   flit,
  output logic    flit_valid,
  input  logic    flit_ready
);

  // ----------------------------------------
  // internal signals
  // ----------------------------------------
  symbol_t sync_q1;   // first sync stage, may be metastable
  symbol_t sync_q2;   // second sync stage, safe to use
  symbol_t level_q;   // nrz level of the last accepted symbol
  symbol_t rtz;       // wires changed since the last symbol
  logic    started;   // first cycle after reset done
  logic    complete;  // two or more wires have changed
  logic    capture;   // take the symbol this edge

  // ----------------------------------------
  // 2-of-7 classifier
  // ----------------------------------------
  function automatic flit_t classify_symbol(input symbol_t sym);
    flit_t f;
    f.kind   = kind_data;
    f.nibble = '0;
    case (sym)
      7'b0010001: f.nibble = 4'h0;
      7'b0010010: f.nibble = 4'h1;
      7'b0010100: f.nibble = 4'h2;
      7'b0011000: f.nibble = 4'h3;
      7'b0100001: f.nibble = 4'h4;
      7'b0100010: f.nibble = 4'h5;
      7'b0100100: f.nibble = 4'h6;
      7'b0101000: f.nibble = 4'h7;
      7'b1000001: f.nibble = 4'h8;
      7'b1000010: f.nibble = 4'h9;
      7'b1000100: f.nibble = 4'ha;
      7'b1001000: f.nibble = 4'hb;
      7'b0000011: f.nibble = 4'hc;
      7'b0000110: f.nibble = 4'hd;
      7'b0001100: f.nibble = 4'he;
      7'b0001001: f.nibble = 4'hf;
      `SPIO_EOP_SYMBOL: f.kind = kind_eop;
      default:    f.kind = kind_error;  // 3+ wires or bad pair
    endcase
    return f;
  endfunction

  // bring the async wires into CLK_IN
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= link_data;
      sync_q2 <= sync_q1;
    end
  end

  // nrz to rtz, only the changed wires remain
  assign rtz = sync_q2 ^ level_q;

  // 0 or 1 changed wire is still arriving, not a symbol yet
  assign complete = !$onehot0(rtz);

  // capture when the flit register is free or being emptied
  assign capture = started && complete && (!flit_valid || flit_ready);

  // ----------------------------------------
  // level, ack and flit registers
  // ----------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      started  <= 1'b0;
      level_q  <= '0;
      link_ack <= 1'b0;      // held low in reset
    end else begin
      started <= 1'b1;
      if (!started) begin
        link_ack <= 1'b1;    // first go-ahead to the sender
      end else if (capture) begin
        level_q  <= sync_q2;  // new reference level
        link_ack <= ~link_ack;  // two-phase ack
      end
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_valid <= 1'b0;
    end else if (capture) begin
      flit_valid <= 1'b1;
    end else if (flit_ready) begin
      flit_valid <= 1'b0;    // consumed, nothing new
    end
  end

  // payload only, qualified by flit_valid
  always_ff @(posedge CLK_IN) begin
    if (capture) begin
      flit <= classify_symbol(rtz);
    end
  end

endmodule

// File: verilog/spio_rx_pkg.sv
`include "spio_rx_config.svh"

package spio_rx_pkg;

  // ----------------------------------------
  // vectors with a meaning
  // ----------------------------------------
  typedef logic [`SPIO_SYMBOL_BITS-1:0] symbol_t;    // wire pattern, nrz or rtz
  typedef logic [`SPIO_NIBBLE_BITS-1:0] nibble_t;    // decoded data value
  typedef logic [`SPIO_PKT_BITS-1:0]    pkt_data_t;  // assembled packet
  typedef logic [`SPIO_COUNT_BITS-1:0]  flit_cnt_t;  // flits seen so far

  // what a captured symbol turned out to be
  typedef enum logic [1:0] {
    kind_data,   // one of the 16 data codes
    kind_eop,    // end of packet
    kind_error   // any other complete symbol
  } flit_kind_t;

  // one decoded symbol, sampler to fsm
  typedef struct packed {
    flit_kind_t kind;
    nibble_t    nibble;  // zero unless kind is data
  } flit_t;

  // packet fsm states
  typedef enum logic [2:0] {
    st_start,      // one cycle after reset
    st_idle,       // waiting for the first nibble
    st_transfer,   // collecting nibbles
    st_wait_send,  // packet complete, output still busy
    st_drop        // bad packet, skipping up to its eop
  } fsm_state_t;

endpackage

// File: include/spio_rx_config.svh
`ifndef SPIO_RX_CONFIG_SVH
`define SPIO_RX_CONFIG_SVH

// ----------------------------------------
// link symbol and data widths
// ----------------------------------------
`define SPIO_SYMBOL_BITS     7            // one wire per bit
`define SPIO_NIBBLE_BITS     4            // payload of one data flit

// ----------------------------------------
// packet geometry
// ----------------------------------------
`define SPIO_PKT_BITS        72           // long packet, with payload
`define SPIO_SHORT_PKT_BITS  40           // short packet, no payload
`define SPIO_SHORT_FLITS     10           // data nibbles in a short packet
`define SPIO_LONG_FLITS      18           // data nibbles in a long packet
`define SPIO_COUNT_BITS      5            // holds up to the long count

`define SPIO_EOP_SYMBOL      7'b1100000   // only the two top wires change

`endif
